/* verilog/lsu_defs.svh */
/*
 * Depths and field widths shared by the load/store unit.
 * Include this in any file that sizes a queue or a bus field.
 */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// queue depths
`define LSU_REQ_DEPTH 4
`define LSU_TAG_DEPTH 4
`define LSU_STQ_DEPTH 4

// core side widths
`define LSU_COMMIT_ID_W 4
`define LSU_REG_ADDR_W 5
`define LSU_XLEN 32

// bus side widths
`define LSU_BUS_DATA_W 64
`define LSU_BUS_ADDR_W 32

`endif

/* verilog/lsu_pkg.sv */
/*
 * Core-side types of the load/store unit: opcodes, register fields,
 * queued requests and the tags kept for outstanding loads.
 */
`include "lsu_defs.svh"

package lsu_pkg;

    // byte offset inside one bus beat
    localparam int BEAT_OFF_W = $clog2(`LSU_BUS_DATA_W / 8);

    // load encodings follow the RISC-V funct3 values
    typedef enum logic [2:0] {
        MEM_LB    = 3'b000,
        MEM_LH    = 3'b001,
        MEM_LW    = 3'b010,
        MEM_LBU   = 3'b100,
        MEM_LHU   = 3'b101,
        MEM_STORE = 3'b111
    } mem_op_e;

    typedef logic [`LSU_REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`LSU_COMMIT_ID_W-1:0] commit_id_t;
    typedef logic [`LSU_XLEN-1:0]        xlen_t;

    typedef struct packed {
        mem_op_e                     op;
        reg_addr_t                   rd;
        commit_id_t                  commit_id;
        logic [`LSU_BUS_ADDR_W-1:0]  addr;
        xlen_t                       wdata;
        logic [`LSU_XLEN/8-1:0]      wmask;
    } lsu_req_t;

    // what the read response needs to finish a load
    typedef struct packed {
        mem_op_e               op;
        reg_addr_t             rd;
        commit_id_t            commit_id;
        logic [BEAT_OFF_W-1:0] addr_lo;
    } load_tag_t;

endpackage

/* verilog/lsu_bus_pkg.sv */
/*
 * Bus-side types of the load/store unit master port.
 * Address, beat data and byte strobes of the read and write channels.
 */
`include "lsu_defs.svh"

package lsu_bus_pkg;

    typedef logic [`LSU_BUS_ADDR_W-1:0] bus_addr_t;

    // one full beat of the data bus
    typedef logic [`LSU_BUS_DATA_W-1:0] bus_data_t;

    // one strobe bit per beat byte
    typedef logic [`LSU_BUS_DATA_W/8-1:0] bus_strb_t;

endpackage

/* verilog/lsu_fifo.sv */
/*
 * Circular queue with an occupancy counter, used for the request,
 * load tag and store data queues. The head is valid while not empty.
 */
module lsu_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push_i,
    input  logic [WIDTH-1:0] push_data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] head_o,
    output logic             empty_o,
    output logic             full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // wrap explicitly so odd depths work too
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // push and pop together leave the count alone
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    assign head_o  = mem[rd_ptr];
    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));

endmodule

/* verilog/lsu_issue.sv */
/*
 * Issue stage of the load/store unit. Offers the request queue head on
 * the read or write address channel and, on the handshake, pops it and
 * files the load tag or the lane-placed store data.
 */
module lsu_issue (
    input  logic                  head_valid_i,
    input  lsu_pkg::lsu_req_t     head_i,
    input  logic                  int_assert_i,
    input  logic                  tag_full_i,
    input  logic                  stq_full_i,
    input  logic                  arready_i,
    input  logic                  awready_i,
    output logic                  head_pop_o,
    output logic                  arvalid_o,
    output lsu_bus_pkg::bus_addr_t araddr_o,
    output logic                  awvalid_o,
    output lsu_bus_pkg::bus_addr_t awaddr_o,
    output logic                  tag_push_o,
    output lsu_pkg::load_tag_t    tag_o,
    output logic                  stq_push_o,
    output lsu_bus_pkg::bus_data_t stq_data_o,
    output lsu_bus_pkg::bus_strb_t stq_strb_o
);

    import lsu_pkg::*;
    import lsu_bus_pkg::*;

    localparam int HALF_STRB_W = $bits(bus_strb_t) / 2;

    logic is_store;
    logic ar_fire;
    logic aw_fire;

    assign is_store = (head_i.op == MEM_STORE);

    // interrupt holds issue, and a full downstream queue blocks the channel
    assign arvalid_o = head_valid_i && !is_store && !int_assert_i && !tag_full_i;
    assign awvalid_o = head_valid_i && is_store && !int_assert_i && !stq_full_i;

    assign araddr_o = head_i.addr;
    assign awaddr_o = head_i.addr;

    assign ar_fire = arvalid_o && arready_i;
    assign aw_fire = awvalid_o && awready_i;

    assign head_pop_o = ar_fire || aw_fire;
    assign tag_push_o = ar_fire;
    assign stq_push_o = aw_fire;

    // only the beat offset is kept for the alignment on return
    always_comb begin
        tag_o.op        = head_i.op;
        tag_o.rd        = head_i.rd;
        tag_o.commit_id = head_i.commit_id;
        tag_o.addr_lo   = head_i.addr[BEAT_OFF_W-1:0];
    end

    // word lane chosen by address bit 2, the other lane is left unstrobed
    always_comb begin
        if (head_i.addr[2]) begin
            stq_data_o = {head_i.wdata, xlen_t'(0)};
            stq_strb_o = {head_i.wmask, {HALF_STRB_W{1'b0}}};
        end else begin
            stq_data_o = {xlen_t'(0), head_i.wdata};
            stq_strb_o = {{HALF_STRB_W{1'b0}}, head_i.wmask};
        end
    end

endmodule

/* verilog/lsu_load_align.sv */
/*
 * Turns a read beat into the register write-back value of a load.
 * The tag supplies the opcode, destination and the byte offset.
 */
`include "lsu_defs.svh"

module lsu_load_align (
    input  lsu_bus_pkg::bus_data_t beat_i,
    input  lsu_pkg::load_tag_t     tag_i,
    output lsu_pkg::xlen_t         wdata_o,
    output lsu_pkg::reg_addr_t     waddr_o,
    output lsu_pkg::commit_id_t    commit_id_o
);

    import lsu_pkg::*;

    xlen_t       word_val;
    logic [7:0]  byte_val;
    logic [15:0] half_val;

    // upper or lower word of the beat
    assign word_val = tag_i.addr_lo[2] ? beat_i[`LSU_BUS_DATA_W-1:`LSU_XLEN]
                                       : beat_i[`LSU_XLEN-1:0];

    always_comb begin
        case (tag_i.addr_lo[1:0])
            2'd0:    byte_val = word_val[7:0];
            2'd1:    byte_val = word_val[15:8];
            2'd2:    byte_val = word_val[23:16];
            default: byte_val = word_val[31:24];
        endcase
    end

    assign half_val = tag_i.addr_lo[1] ? word_val[31:16] : word_val[15:0];

    always_comb begin
        case (tag_i.op)
            MEM_LB:  wdata_o = {{(`LSU_XLEN - 8){byte_val[7]}}, byte_val};
            MEM_LH:  wdata_o = {{(`LSU_XLEN - 16){half_val[15]}}, half_val};
            MEM_LBU: wdata_o = {{(`LSU_XLEN - 8){1'b0}}, byte_val};
            MEM_LHU: wdata_o = {{(`LSU_XLEN - 16){1'b0}}, half_val};
            // lw, stores never carry a tag
            default: wdata_o = word_val;
        endcase
    end

    assign waddr_o     = tag_i.rd;
    assign commit_id_o = tag_i.commit_id;

endmodule

/* verilog/lsu_top.sv */
/*
 * Load/store unit top level. Requests from execute pass through a queue,
 * loads go out on the read channel and return in order to write-back,
 * stores go out on the write address and data channels.
 */
`include "lsu_defs.svh"

module lsu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // execute stage
    input  logic                   req_mem_i,
    input  lsu_pkg::mem_op_e       mem_op_i,
    input  lsu_pkg::reg_addr_t     rd_addr_i,
    input  lsu_pkg::commit_id_t    commit_id_i,
    input  lsu_bus_pkg::bus_addr_t mem_addr_i,
    input  lsu_pkg::xlen_t         mem_wdata_i,
    input  logic [`LSU_XLEN/8-1:0] mem_wmask_i,
    input  logic                   int_assert_i,
    output logic                   mem_stall_o,
    output logic                   mem_busy_o,
    // register write-back
    output logic                   reg_we_o,
    output lsu_pkg::reg_addr_t     reg_waddr_o,
    output lsu_pkg::xlen_t         reg_wdata_o,
    output lsu_pkg::commit_id_t    commit_id_o,
    // read address and data
    output logic                   arvalid_o,
    input  logic                   arready_i,
    output lsu_bus_pkg::bus_addr_t araddr_o,
    input  logic                   rvalid_i,
    input  lsu_bus_pkg::bus_data_t rdata_i,
    // write address and data
    output logic                   awvalid_o,
    input  logic                   awready_i,
    output lsu_bus_pkg::bus_addr_t awaddr_o,
    output logic                   wvalid_o,
    input  logic                   wready_i,
    output lsu_bus_pkg::bus_data_t wdata_o,
    output lsu_bus_pkg::bus_strb_t wstrb_o
);

    import lsu_pkg::*;
    import lsu_bus_pkg::*;

    localparam int REQ_W = $bits(lsu_req_t);
    localparam int TAG_W = $bits(load_tag_t);
    localparam int STQ_W = $bits(bus_data_t) + $bits(bus_strb_t);

    lsu_req_t   req_in;
    lsu_req_t   req_head;
    logic       req_push;
    logic       req_pop;
    logic       req_empty;
    logic       req_full;

    load_tag_t  tag_in;
    load_tag_t  tag_head;
    logic       tag_push;
    logic       tag_full;

    bus_data_t  stq_data;
    bus_strb_t  stq_strb;
    logic       stq_push;
    logic       stq_pop;
    logic       stq_empty;
    logic       stq_full;

    // a request is refused during an interrupt and held while the queue is full
    assign mem_stall_o = req_mem_i && !int_assert_i && req_full;
    assign req_push    = req_mem_i && !int_assert_i && !req_full;

    always_comb begin
        req_in.op        = mem_op_i;
        req_in.rd        = rd_addr_i;
        req_in.commit_id = commit_id_i;
        req_in.addr      = mem_addr_i;
        req_in.wdata     = mem_wdata_i;
        req_in.wmask     = mem_wmask_i;
    end

    lsu_fifo #(
        .DEPTH (`LSU_REQ_DEPTH),
        .WIDTH (REQ_W)
    ) u_req_q (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (req_push),
        .push_data_i (req_in),
        .pop_i       (req_pop),
        .head_o      (req_head),
        .empty_o     (req_empty),
        .full_o      (req_full)
    );

    lsu_issue u_issue (
        .head_valid_i (!req_empty),
        .head_i       (req_head),
        .int_assert_i (int_assert_i),
        .tag_full_i   (tag_full),
        .stq_full_i   (stq_full),
        .arready_i    (arready_i),
        .awready_i    (awready_i),
        .head_pop_o   (req_pop),
        .arvalid_o    (arvalid_o),
        .araddr_o     (araddr_o),
        .awvalid_o    (awvalid_o),
        .awaddr_o     (awaddr_o),
        .tag_push_o   (tag_push),
        .tag_o        (tag_in),
        .stq_push_o   (stq_push),
        .stq_data_o   (stq_data),
        .stq_strb_o   (stq_strb)
    );

    // responses arrive in order, so each beat retires the oldest tag
    lsu_fifo #(
        .DEPTH (`LSU_TAG_DEPTH),
        .WIDTH (TAG_W)
    ) u_tag_q (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (tag_push),
        .push_data_i (tag_in),
        .pop_i       (rvalid_i),
        .head_o      (tag_head),
        .empty_o     (),
        .full_o      (tag_full)
    );

    // store data waits here for the write data channel
    assign stq_pop = wvalid_o && wready_i;

    lsu_fifo #(
        .DEPTH (`LSU_STQ_DEPTH),
        .WIDTH (STQ_W)
    ) u_stq (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (stq_push),
        .push_data_i ({stq_data, stq_strb}),
        .pop_i       (stq_pop),
        .head_o      ({wdata_o, wstrb_o}),
        .empty_o     (stq_empty),
        .full_o      (stq_full)
    );

    assign wvalid_o = !stq_empty;

    lsu_load_align u_load_align (
        .beat_i      (rdata_i),
        .tag_i       (tag_head),
        .wdata_o     (reg_wdata_o),
        .waddr_o     (reg_waddr_o),
        .commit_id_o (commit_id_o)
    );

    // every beat is taken, rready is tied high on the slave side
    assign reg_we_o = rvalid_i;

    assign mem_busy_o = !req_empty || !stq_empty;

endmodule

/* test/lsu_bus_model.sv */
/*
 * Memory slave for the load/store unit testbench. 64 beats of 64 bits,
 * random ready stalls and in-order read data one to three cycles late.
 */
module lsu_bus_model (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ar_hold_i,
    input  logic                   arvalid_i,
    output logic                   arready_o,
    input  lsu_bus_pkg::bus_addr_t araddr_i,
    output logic                   rvalid_o,
    output lsu_bus_pkg::bus_data_t rdata_o,
    input  logic                   awvalid_i,
    output logic                   awready_o,
    input  lsu_bus_pkg::bus_addr_t awaddr_i,
    input  logic                   wvalid_i,
    output logic                   wready_o,
    input  lsu_bus_pkg::bus_data_t wdata_i,
    input  lsu_bus_pkg::bus_strb_t wstrb_i
);

    import lsu_bus_pkg::*;

    bus_data_t mem [64];
    bus_addr_t rd_addr_q [$];
    int        rd_due_q [$];
    bus_addr_t wr_addr_q [$];
    int        cycle;
    logic      hold;
    logic      live;

    task automatic fill_random();
        for (int i = 0; i < 64; i++) begin
            mem[i] = {$urandom, $urandom};
        end
    endtask

    task automatic write_beat(input bus_addr_t addr, input bus_data_t data, input bus_strb_t strb);
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                mem[addr[8:3]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    initial begin
        arready_o = 1'b0;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        rvalid_o  = 1'b0;
        rdata_o   = '0;
        cycle     = 0;
        forever begin
            @(posedge clk);
            live = rst_n;
            hold = ar_hold_i;
            if (!live) begin
                rd_addr_q.delete();
                rd_due_q.delete();
                wr_addr_q.delete();
            end else begin
                cycle++;
                // the beat shown in the last cycle is taken at this edge
                if (rvalid_o) begin
                    void'(rd_addr_q.pop_front());
                    void'(rd_due_q.pop_front());
                end
                if (arvalid_i && arready_o) begin
                    rd_addr_q.push_back(araddr_i);
                    rd_due_q.push_back(cycle + $urandom_range(2, 0));
                end
                // data always follows its address, so the queue is never empty here
                if (wvalid_i && wready_o) begin
                    write_beat(wr_addr_q.pop_front(), wdata_i, wstrb_i);
                end
                if (awvalid_i && awready_o) begin
                    wr_addr_q.push_back(awaddr_i);
                end
            end
            #1;
            arready_o = live && !hold && ($urandom_range(3, 0) != 0);
            awready_o = live && ($urandom_range(3, 0) != 0);
            wready_o  = live && ($urandom_range(3, 0) != 0);
            rvalid_o  = live && (rd_due_q.size() != 0) && (rd_due_q[0] <= cycle);
            rdata_o   = rvalid_o ? mem[rd_addr_q[0][8:3]] : '0;
        end
    end

endmodule

/* test/lsu_assertions.sv */
/*
 * Concurrent checks on the load/store unit queues and bus channels.
 * Bound into every lsu_top instance; failures are counted in fail_count.
 */
module lsu_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   int_assert_i,
    input logic                   req_push_i,
    input logic                   req_full_i,
    input logic                   tag_push_i,
    input logic                   tag_full_i,
    input logic                   tag_empty_i,
    input logic                   stq_push_i,
    input logic                   stq_full_i,
    input logic                   arvalid_i,
    input logic                   arready_i,
    input lsu_bus_pkg::bus_addr_t araddr_i,
    input logic                   rvalid_i,
    input logic                   wvalid_i,
    input logic                   wready_i,
    input lsu_bus_pkg::bus_data_t wdata_i,
    input lsu_bus_pkg::bus_strb_t wstrb_i
);

    int fail_count = 0;

    no_full_push: assert property (@(posedge clk) disable iff (!rst_n)
        !((req_push_i && req_full_i) || (tag_push_i && tag_full_i) || (stq_push_i && stq_full_i)))
    else begin
        fail_count++;
        $error("push into a full queue");
    end

    no_orphan_beat: assert property (@(posedge clk) disable iff (!rst_n)
        !(rvalid_i && tag_empty_i))
    else begin
        fail_count++;
        $error("read beat with no load tag queued");
    end

    // an interrupt withdraws a waiting read request
    ar_held: assert property (@(posedge clk) disable iff (!rst_n)
        (arvalid_i && !arready_i) |=> (int_assert_i || (arvalid_i && $stable(araddr_i))))
    else begin
        fail_count++;
        $error("read address request dropped or changed before ready");
    end

    w_held: assert property (@(posedge clk) disable iff (!rst_n)
        (wvalid_i && !wready_i) |=> (wvalid_i && $stable(wdata_i) && $stable(wstrb_i)))
    else begin
        fail_count++;
        $error("write data dropped or changed before ready");
    end

endmodule

bind lsu_top lsu_assertions u_checks (
    .clk          (clk),
    .rst_n        (rst_n),
    .int_assert_i (int_assert_i),
    .req_push_i   (req_push),
    .req_full_i   (req_full),
    .tag_push_i   (tag_push),
    .tag_full_i   (tag_full),
    .tag_empty_i  (u_tag_q.empty_o),
    .stq_push_i   (stq_push),
    .stq_full_i   (stq_full),
    .arvalid_i    (arvalid_o),
    .arready_i    (arready_i),
    .araddr_i     (araddr_o),
    .rvalid_i     (rvalid_i),
    .wvalid_i     (wvalid_o),
    .wready_i     (wready_i),
    .wdata_i      (wdata_o),
    .wstrb_i      (wstrb_o)
);

/* test/tb_lsu.sv */
/*
 * Testbench for the load/store unit. Directed tests drive lsu_top against
 * a memory model; a shadow copy of the memory predicts every write-back.
 */
module tb_lsu;

    import lsu_pkg::*;
    import lsu_bus_pkg::*;

    typedef struct {
        reg_addr_t  rd;
        commit_id_t cid;
        xlen_t      value;
    } wb_t;

    logic       clk;
    logic       rst_n;
    logic       req_mem_i;
    mem_op_e    mem_op_i;
    reg_addr_t  rd_addr_i;
    commit_id_t commit_id_i;
    bus_addr_t  mem_addr_i;
    xlen_t      mem_wdata_i;
    logic [3:0] mem_wmask_i;
    logic       int_assert_i;
    logic       mem_stall_o;
    logic       mem_busy_o;
    logic       reg_we_o;
    reg_addr_t  reg_waddr_o;
    xlen_t      reg_wdata_o;
    commit_id_t commit_id_o;
    logic       arvalid_o;
    logic       arready_i;
    logic       rvalid_i;
    logic       awvalid_o;
    logic       awready_i;
    logic       wvalid_o;
    logic       wready_i;
    bus_addr_t  araddr_o;
    bus_addr_t  awaddr_o;
    bus_data_t  rdata_i;
    bus_data_t  wdata_o;
    bus_strb_t  wstrb_o;
    logic       ar_hold;

    bus_data_t  shadow [64];
    wb_t        exp_q [$];
    int         tag_seq;
    int         inflight;
    int         max_inflight;

    lsu_top lsu_top_inst (.*);

    lsu_bus_model u_bus (
        .clk       (clk),
        .rst_n     (rst_n),
        .ar_hold_i (ar_hold),
        .arvalid_i (arvalid_o),
        .arready_o (arready_i),
        .araddr_i  (araddr_o),
        .rvalid_o  (rvalid_i),
        .rdata_o   (rdata_i),
        .awvalid_i (awvalid_o),
        .awready_o (awready_i),
        .awaddr_i  (awaddr_o),
        .wvalid_i  (wvalid_o),
        .wready_o  (wready_i),
        .wdata_i   (wdata_o),
        .wstrb_i   (wstrb_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("[ERROR] time %0t: %s: got %0h, expected %0h",
                               $time, what, got, exp));
        end
    endtask

    // word by address bit 2, then byte or halfword by bits 1:0
    function automatic xlen_t expected_load(input mem_op_e op, input bus_addr_t addr);
        xlen_t       word;
        logic [7:0]  b;
        logic [15:0] h;
        word = addr[2] ? shadow[addr[8:3]][63:32] : shadow[addr[8:3]][31:0];
        b = word[8*addr[1:0] +: 8];
        h = word[16*addr[1] +: 16];
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LBU: return {24'b0, b};
            MEM_LHU: return {16'b0, h};
            default: return word;
        endcase
    endfunction

    // holds the request until it is taken, then records what it should do
    task automatic send_req(input mem_op_e op, input bus_addr_t addr, input xlen_t wdata,
                            input logic [3:0] mask);
        int   waited;
        logic stalled;
        wb_t  e;
        req_mem_i   = 1'b1;
        mem_op_i    = op;
        rd_addr_i   = reg_addr_t'(tag_seq);
        commit_id_i = commit_id_t'(tag_seq * 7);
        mem_addr_i  = addr;
        mem_wdata_i = wdata;
        mem_wmask_i = mask;
        waited = 0;
        do begin
            @(negedge clk);
            stalled = mem_stall_o;
            @(posedge clk);
            #1;
            waited++;
            if (waited > 200) stop_run("request never left the stall");
        end while (stalled);
        req_mem_i = 1'b0;
        if (op == MEM_STORE) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) shadow[addr[8:3]][32*addr[2] + 8*b +: 8] = wdata[8*b +: 8];
            end
        end else begin
            e = '{rd: rd_addr_i, cid: commit_id_i, value: expected_load(op, addr)};
            exp_q.push_back(e);
        end
        tag_seq++;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || mem_busy_o) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 500) stop_run("unit did not drain before the timeout");
        end
    endtask

    // write-back compare and count of loads out on the bus
    always @(negedge clk) begin
        wb_t e;
        if (rst_n) begin
            if (arvalid_o && arready_i) inflight++;
            if (reg_we_o) begin
                if (exp_q.size() == 0) begin
                    stop_run("register write-back with no load pending");
                end else begin
                    e = exp_q.pop_front();
                    check_value("write-back register", reg_waddr_o, e.rd);
                    check_value("write-back commit id", commit_id_o, e.cid);
                    check_value("write-back data", reg_wdata_o, e.value);
                    inflight--;
                end
            end
            if (inflight > max_inflight) max_inflight = inflight;
        end
    end

    task automatic test_load_kinds();
        mem_op_e ops [5] = '{MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
        logic    misaligned;
        for (int k = 0; k < 5; k++) begin
            for (int off = 0; off < 8; off++) begin
                // halfwords and words stay naturally aligned
                misaligned = (ops[k] inside {MEM_LH, MEM_LHU} && off[0]) ||
                             (ops[k] == MEM_LW && off[1:0] != 0);
                if (misaligned)
                    continue;
                send_req(ops[k], bus_addr_t'(8 * (k * 8 + off) + off), '0, '0);
            end
        end
        wait_idle();
    endtask

    task automatic test_store_merge();
        for (int i = 0; i < 16; i++) begin
            send_req(MEM_STORE, bus_addr_t'(8 * (40 + i % 8) + 4 * (i % 2)), $urandom,
                     4'(i * 5 + 1));
        end
        wait_idle();
        for (int i = 0; i < 16; i++) begin
            send_req(MEM_LW, bus_addr_t'(8 * (40 + i / 2) + 4 * (i % 2)), '0, '0);
        end
        wait_idle();
    endtask

    task automatic test_outstanding();
        max_inflight = 0;
        for (int i = 0; i < 16; i++) begin
            send_req(MEM_LW, bus_addr_t'($urandom_range(127, 0) * 4), '0, '0);
        end
        wait_idle();
        check_value("several loads outstanding", max_inflight >= 2, 1'b1);
    endtask

    task automatic test_queue_full();
        ar_hold = 1'b1;
        for (int i = 0; i < 4; i++) begin
            send_req(MEM_LBU, bus_addr_t'(8 * i + i), '0, '0);
        end
        fork
            begin
                @(negedge clk);
                check_value("stall with a full request queue", mem_stall_o, 1'b1);
                @(posedge clk);
                #1;
                ar_hold = 1'b0;
            end
        join_none
        send_req(MEM_LH, 32'h2a, '0, '0);
        wait_idle();
    endtask

    task automatic test_interrupt();
        send_req(MEM_STORE, 32'h1f0, $urandom, 4'b1001);
        send_req(MEM_LW, 32'h1c4, '0, '0);
        int_assert_i = 1'b1;
        // offered during the interrupt and never taken
        req_mem_i = 1'b1;
        mem_op_i  = MEM_LB;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_value("arvalid during interrupt", arvalid_o, 1'b0);
            check_value("awvalid during interrupt", awvalid_o, 1'b0);
            check_value("stall during interrupt", mem_stall_o, 1'b0);
            @(posedge clk);
            #1;
        end
        check_value("busy with queued work", mem_busy_o, 1'b1);
        req_mem_i    = 1'b0;
        int_assert_i = 1'b0;
        wait_idle();
        send_req(MEM_LW, 32'h1f0, '0, '0);
        wait_idle();
    endtask

    initial begin
        void'($urandom(32'hcd4e));
        rst_n        = 1'b0;
        req_mem_i    = 1'b0;
        mem_op_i     = MEM_LW;
        rd_addr_i    = '0;
        commit_id_i  = '0;
        mem_addr_i   = '0;
        mem_wdata_i  = '0;
        mem_wmask_i  = '0;
        int_assert_i = 1'b0;
        ar_hold      = 1'b0;
        tag_seq      = 0;
        inflight     = 0;
        max_inflight = 0;
        u_bus.fill_random();
        for (int i = 0; i < 64; i++) begin
            shadow[i] = u_bus.mem[i];
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("outputs after reset",
                    {arvalid_o, awvalid_o, wvalid_o, reg_we_o, mem_stall_o, mem_busy_o}, '0);
        test_load_kinds();
        test_store_merge();
        test_outstanding();
        test_queue_full();
        test_interrupt();
        if (lsu_top_inst.u_checks.fail_count != 0) begin
            stop_run("bound assertions reported failures");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

/* tb.f */
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_bus_pkg.sv
verilog/lsu_fifo.sv
verilog/lsu_issue.sv
verilog/lsu_load_align.sv
verilog/lsu_top.sv
test/lsu_bus_model.sv
test/lsu_assertions.sv
test/tb_lsu.sv

/* Bender.yml */
package:
  name: lsu

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/lsu_pkg.sv
      - verilog/lsu_bus_pkg.sv
      - verilog/lsu_fifo.sv
      - verilog/lsu_issue.sv
      - verilog/lsu_load_align.sv
      - verilog/lsu_top.sv
  - target: test
    files:
      - test/lsu_bus_model.sv
      - test/lsu_assertions.sv
      - test/tb_lsu.sv
